// File: hw/exu_div.sv
`timescale 1ns/10ps

module exu_div #(
    parameter int XLEN = 32
) (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              start_i,     // held high for the whole divide
    input  muldiv_pkg::muldiv_op_e            op_i,
    input  logic [XLEN-1:0]                   dividend_i,
    input  logic [XLEN-1:0]                   divisor_i,
    input  logic [muldiv_pkg::REG_ADDR_W-1:0] rd_i,
    output logic [XLEN-1:0]                   result_o,
    output logic                              ready_o,     // one-cycle result strobe
    output logic                              busy_o,
    output logic [muldiv_pkg::REG_ADDR_W-1:0] rd_o
);
    import muldiv_pkg::*;

    localparam int CNT_W = $clog2(XLEN);

    div_state_e       state_q;
    muldiv_op_e       op_q;
    logic [XLEN-1:0]  dividend_q;  // shifted left, msb feeds the trial
    logic [XLEN-1:0]  divisor_q;
    logic [XLEN-1:0]  quot_q;
    logic [XLEN-1:0]  rem_q;       // partial remainder
    logic [CNT_W-1:0] cnt_q;
    logic             neg_q;       // negate the final value
    logic             done_q;      // result given, request still held

    logic            div_req;
    logic            accept;
    logic            is_signed;
    logic            want_quot;
    logic            dividend_neg;
    logic            divisor_neg;
    logic [XLEN:0]   trial;
    logic            trial_ge;
    logic [XLEN-1:0] trial_sub;
    logic [XLEN-1:0] rem_nxt;
    logic [XLEN-1:0] quot_nxt;
    logic [XLEN-1:0] final_val;

    // only divide-class ops start this unit
    assign div_req = start_i && op_i[3];
    // a held request is not taken twice, it must drop first
    assign accept  = (state_q == DIV_IDLE) && div_req && !done_q;

    assign is_signed    = (op_q == OP_DIV) || (op_q == OP_REM);
    assign want_quot    = (op_q == OP_DIV) || (op_q == OP_DIVU);
    assign dividend_neg = is_signed && dividend_q[XLEN-1];
    assign divisor_neg  = is_signed && divisor_q[XLEN-1];

    // restoring trial subtraction, one bit
    assign trial     = {rem_q, dividend_q[XLEN-1]};
    assign trial_ge  = trial >= {1'b0, divisor_q};
    assign trial_sub = trial[XLEN-1:0] - divisor_q;  // fits when trial_ge
    assign rem_nxt   = trial_ge ? trial_sub : trial[XLEN-1:0];
    assign quot_nxt  = {quot_q[XLEN-2:0], trial_ge};

    // the last bit is resolved in DIV_END together with the selection
    assign final_val = want_quot ? quot_nxt : rem_nxt;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= DIV_IDLE;
            ready_o <= 1'b0;
            busy_o  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            ready_o <= 1'b0;
            case (state_q)
                DIV_IDLE: begin
                    if (accept) begin
                        state_q <= DIV_START;
                        busy_o  <= 1'b1;
                    end else if (!div_req) begin
                        done_q <= 1'b0;
                    end
                end
                DIV_START: begin
                    if (!start_i) begin
                        state_q <= DIV_IDLE;  // abort
                        busy_o  <= 1'b0;
                    end else if (divisor_q == '0) begin
                        state_q <= DIV_IDLE;
                        ready_o <= 1'b1;
                        busy_o  <= 1'b0;
                        done_q  <= 1'b1;
                    end else begin
                        state_q <= DIV_CALC;
                    end
                end
                DIV_CALC: begin
                    if (!start_i) begin
                        state_q <= DIV_IDLE;
                        busy_o  <= 1'b0;
                    end else if (cnt_q == '0) begin
                        state_q <= DIV_END;
                    end
                end
                DIV_END: begin
                    state_q <= DIV_IDLE;
                    busy_o  <= 1'b0;
                    if (start_i) begin
                        ready_o <= 1'b1;
                        done_q  <= 1'b1;
                    end
                end
                default: begin
                    state_q <= DIV_IDLE;
                    busy_o  <= 1'b0;
                end
            endcase
        end
    end

    // datapath, follows the state register
    always_ff @(posedge clk) begin
        case (state_q)
            DIV_IDLE: begin
                if (accept) begin
                    op_q       <= op_i;
                    dividend_q <= dividend_i;
                    divisor_q  <= divisor_i;
                    rd_o       <= rd_i;
                end
            end
            DIV_START: begin
                if (divisor_q == '0) begin
                    result_o <= want_quot ? '1 : dividend_q;
                end else begin
                    // work on magnitudes, sign restored at the end
                    dividend_q <= dividend_neg ? -dividend_q : dividend_q;
                    divisor_q  <= divisor_neg ? -divisor_q : divisor_q;
                    rem_q      <= '0;
                    quot_q     <= '0;
                    cnt_q      <= CNT_W'(XLEN - 2);  // XLEN-1 calc cycles
                    neg_q      <= want_quot ? (dividend_neg ^ divisor_neg) : dividend_neg;
                end
            end
            DIV_CALC: begin
                dividend_q <= {dividend_q[XLEN-2:0], 1'b0};
                rem_q      <= rem_nxt;
                quot_q     <= quot_nxt;
                cnt_q      <= cnt_q - 1'b1;
            end
            DIV_END: begin
                result_o <= neg_q ? -final_val : final_val;
            end
            default: begin
                cnt_q <= '0;
            end
        endcase
    end

endmodule

// File: hw/exu_mul.sv
`timescale 1ns/10ps

module exu_mul #(
    parameter int XLEN = 32
) (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              valid_i,
    input  muldiv_pkg::muldiv_op_e            op_i,
    input  logic [XLEN-1:0]                   rs1_i,
    input  logic [XLEN-1:0]                   rs2_i,
    input  logic [muldiv_pkg::REG_ADDR_W-1:0] rd_i,
    output logic                              valid_o,
    output logic [XLEN-1:0]                   result_o,
    output logic [muldiv_pkg::REG_ADDR_W-1:0] rd_o
);
    import muldiv_pkg::*;

    // stage 1 registers
    logic signed [XLEN:0]  a_q;
    logic signed [XLEN:0]  b_q;
    muldiv_op_e            op_q;
    logic [REG_ADDR_W-1:0] rd_q;
    logic                  v1_q;

    logic            a_signed;
    logic            b_signed;
    logic [2*XLEN-1:0] prod;

    // MUL takes the low half, so its extension does not matter
    assign a_signed = (op_i == OP_MULH) || (op_i == OP_MULHSU);
    assign b_signed = (op_i == OP_MULH);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            v1_q <= 1'b0;
        end else begin
            v1_q <= valid_i && !op_i[3];  // multiply class only
        end
    end

    always_ff @(posedge clk) begin
        a_q  <= {a_signed && rs1_i[XLEN-1], rs1_i};
        b_q  <= {b_signed && rs2_i[XLEN-1], rs2_i};
        op_q <= op_i;
        rd_q <= rd_i;
    end

    // signed XLEN+1 operands cover all four signedness cases
    assign prod = {{(XLEN-1){a_q[XLEN]}}, a_q} * {{(XLEN-1){b_q[XLEN]}}, b_q};

    // stage 2
    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= v1_q;
        end
    end

    always_ff @(posedge clk) begin
        if (op_q == OP_MUL) begin
            result_o <= prod[XLEN-1:0];
        end else begin
            result_o <= prod[2*XLEN-1:XLEN];
        end
        rd_o <= rd_q;
    end

endmodule

// File: hw/exu_muldiv.sv
`timescale 1ns/10ps

module exu_muldiv #(
    parameter int XLEN = 32
) (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              req_valid_i,
    input  muldiv_pkg::muldiv_op_e            op_i,
    input  logic [XLEN-1:0]                   rs1_i,
    input  logic [XLEN-1:0]                   rs2_i,
    input  logic [muldiv_pkg::REG_ADDR_W-1:0] rd_i,
    output logic                              wb_valid_o,
    output logic [XLEN-1:0]                   wb_data_o,
    output logic [muldiv_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic                              busy_o
);
    import muldiv_pkg::*;

    logic                  mul_valid;
    logic [XLEN-1:0]       mul_data;
    logic [REG_ADDR_W-1:0] mul_rd;
    logic                  div_ready;
    logic [XLEN-1:0]       div_result;
    logic [REG_ADDR_W-1:0] div_rd;
    logic                  div_busy;

    // both units see every request and pick their own class
    exu_mul #(
        .XLEN(XLEN)
    ) i_mul (
        .clk      (clk),
        .rst_i    (rst_i),
        .valid_i  (req_valid_i),
        .op_i     (op_i),
        .rs1_i    (rs1_i),
        .rs2_i    (rs2_i),
        .rd_i     (rd_i),
        .valid_o  (mul_valid),
        .result_o (mul_data),
        .rd_o     (mul_rd)
    );

    exu_div #(
        .XLEN(XLEN)
    ) i_div (
        .clk        (clk),
        .rst_i      (rst_i),
        .start_i    (req_valid_i),
        .op_i       (op_i),
        .dividend_i (rs1_i),
        .divisor_i  (rs2_i),
        .rd_i       (rd_i),
        .result_o   (div_result),
        .ready_o    (div_ready),
        .busy_o     (div_busy),
        .rd_o       (div_rd)
    );

    muldiv_wb #(
        .XLEN(XLEN)
    ) i_wb (
        .clk         (clk),
        .rst_i       (rst_i),
        .mul_valid_i (mul_valid),
        .mul_data_i  (mul_data),
        .mul_rd_i    (mul_rd),
        .div_ready_i (div_ready),
        .div_data_i  (div_result),
        .div_rd_i    (div_rd),
        .div_busy_i  (div_busy),
        .wb_valid_o  (wb_valid_o),
        .wb_data_o   (wb_data_o),
        .wb_rd_o     (wb_rd_o),
        .busy_o      (busy_o)
    );

endmodule

// File: hw/muldiv_pkg.sv
package muldiv_pkg;

    // width of a destination register index
    localparam int REG_ADDR_W = 5;

    // M-extension operations
    // bit 3 set means the op belongs to the divider, clear means the multiplier
    typedef enum logic [3:0] {
        OP_MUL    = 4'b0000,  // low half of product
        OP_MULH   = 4'b0001,  // high half, signed x signed
        OP_MULHSU = 4'b0010,  // high half, signed x unsigned
        OP_MULHU  = 4'b0011,  // high half, unsigned x unsigned
        OP_DIV    = 4'b1000,
        OP_DIVU   = 4'b1001,
        OP_REM    = 4'b1010,
        OP_REMU   = 4'b1011
    } muldiv_op_e;

    // divider state, one-hot
    typedef enum logic [3:0] {
        DIV_IDLE  = 4'b0001,  // waiting for a divide request
        DIV_START = 4'b0010,  // zero divisor check and sign fixup
        DIV_CALC  = 4'b0100,  // one quotient bit per cycle
        DIV_END   = 4'b1000   // last bit, select and negate
    } div_state_e;

endpackage

// File: hw/muldiv_wb.sv
`timescale 1ns/10ps

module muldiv_wb #(
    parameter int XLEN = 32
) (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              mul_valid_i,
    input  logic [XLEN-1:0]                   mul_data_i,
    input  logic [muldiv_pkg::REG_ADDR_W-1:0] mul_rd_i,
    input  logic                              div_ready_i,
    input  logic [XLEN-1:0]                   div_data_i,
    input  logic [muldiv_pkg::REG_ADDR_W-1:0] div_rd_i,
    input  logic                              div_busy_i,
    output logic                              wb_valid_o,
    output logic [XLEN-1:0]                   wb_data_o,
    output logic [muldiv_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic                              busy_o
);

    // one write port, valid for a single cycle per result
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= div_ready_i || mul_valid_i;
        end
    end

    // divider first, the two never land on the same cycle anyway
    always_ff @(posedge clk) begin
        if (div_ready_i) begin
            wb_data_o <= div_data_i;
            wb_rd_o   <= div_rd_i;
        end else if (mul_valid_i) begin
            wb_data_o <= mul_data_i;
            wb_rd_o   <= mul_rd_i;
        end
    end

    // single stall toward the requester
    // multiplies never stall, only a divide in flight does
    assign busy_o = div_busy_i;

endmodule

// File: run_sim.sh
#!/bin/bash
# compile with Verilator and run; status follows the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_muldiv --Mdir obj_dir \
    && ./obj_dir/Vtb_muldiv +verilator+error+limit+1000 \
    | tee /dev/stderr | grep -q "SIMULATION PASSED" \
    && echo "run ok" \
    || { echo "run not ok"; exit 1; }

// File: verification/tb_muldiv.sv
`timescale 1ns/10ps

module tb_muldiv;
    import muldiv_pkg::*;

    localparam int XLEN    = 32;
    localparam int TIMEOUT = 20000;  // ~200 muls and ~50 divides need well under this

    logic                  clk;
    logic                  rst_i;
    logic                  req_valid_i;
    muldiv_op_e            op_i;
    logic [XLEN-1:0]       rs1_i;
    logic [XLEN-1:0]       rs2_i;
    logic [REG_ADDR_W-1:0] rd_i;
    logic                  wb_valid_o;
    logic [XLEN-1:0]       wb_data_o;
    logic [REG_ADDR_W-1:0] wb_rd_o;
    logic                  busy_o;

    logic [31:0]           lfsr = 32'd70264;
    int                    rd_cnt = 0;
    int                    cycles = 0;
    int                    errs;

    exu_muldiv #(
        .XLEN(XLEN)
    ) i_dut (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .op_i        (op_i),
        .rs1_i       (rs1_i),
        .rs2_i       (rs2_i),
        .rd_i        (rd_i),
        .wb_valid_o  (wb_valid_o),
        .wb_data_o   (wb_data_o),
        .wb_rd_o     (wb_rd_o),
        .busy_o      (busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [XLEN-1:0] pick_operand();
        logic [2:0] sel;
        sel = 3'(rand_bits(3));
        case (sel)
            3'd0:    return '0;
            3'd1:    return 32'd1;
            3'd2:    return '1;
            3'd3:    return 32'h8000_0000;
            default: return rand_bits(32);
        endcase
    endfunction

    function automatic logic [REG_ADDR_W-1:0] take_rd();
        rd_cnt = (rd_cnt + 1) % 32;
        return REG_ADDR_W'(rd_cnt);
    endfunction

    task automatic drive_req(input logic v, input muldiv_op_e op, input logic [XLEN-1:0] a,
                             input logic [XLEN-1:0] b, input logic [REG_ADDR_W-1:0] rd);
        @(posedge clk);
        req_valid_i <= v;
        op_i        <= op;
        rs1_i       <= a;
        rs2_i       <= b;
        rd_i        <= rd;
    endtask

    // hold the request until its writeback, then drop it
    task automatic run_div(input muldiv_op_e op, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b);
        logic [REG_ADDR_W-1:0] rd;
        rd = take_rd();
        drive_req(1'b1, op, a, b, rd);
        do @(negedge clk); while (!(wb_valid_o && wb_rd_o == rd));
        drive_req(1'b0, op, a, b, rd);
    endtask

    task automatic mul_burst(input int len);
        for (int k = 0; k < len; k++) begin
            drive_req(1'b1, muldiv_op_e'({2'b00, 2'(rand_bits(2))}), pick_operand(),
                      pick_operand(), take_rd());
        end
        drive_req(1'b0, OP_MUL, '0, '0, '0);
    endtask

    initial begin
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rst_i       = 1'b1;
        req_valid_i = 1'b0;
        op_i        = OP_MUL;
        rs1_i       = '0;
        rs2_i       = '0;
        rd_i        = '0;
        repeat (8) @(posedge clk);
        rst_i <= 1'b0;
        repeat (2) @(posedge clk);

        // mixed traffic, a few muls then a divide per round
        for (int r = 0; r < 40; r++) begin
            mul_burst(1 + int'(rand_bits(2)));
            mul_burst(5 - ((r % 4) + 1) + 1);
            run_div(muldiv_op_e'({2'b10, 2'(rand_bits(2))}), pick_operand(), pick_operand());
        end

        // zero divisor and signed overflow
        run_div(OP_DIV, rand_bits(32), '0);
        run_div(OP_DIVU, rand_bits(32), '0);
        run_div(OP_REM, rand_bits(32), '0);
        run_div(OP_REMU, rand_bits(32), '0);
        run_div(OP_DIV, 32'h8000_0000, '1);
        run_div(OP_REM, 32'h8000_0000, '1);

        // abort in the middle of the calculation
        drive_req(1'b1, OP_DIVU, 32'h1234_5678, 32'd7, take_rd());
        repeat (10) @(posedge clk);
        drive_req(1'b0, OP_DIVU, '0, '0, '0);
        repeat (45) @(posedge clk);
        // abort right after acceptance
        drive_req(1'b1, OP_REM, 32'hdead_beef, 32'd3, take_rd());
        drive_req(1'b0, OP_REM, '0, '0, '0);
        repeat (45) @(posedge clk);
        run_div(OP_DIV, 32'hffff_ff00, 32'd5);
        mul_burst(3);

        repeat (10) @(posedge clk);
        errs = i_dut.i_chk.err_cnt;
        $display("errors: %0d", errs);
        if (errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: verification/tb_muldiv_asserts.sv
`timescale 1ns/10ps

module tb_muldiv_asserts #(
    parameter int XLEN = 32
) (
    input logic                              clk,
    input logic                              rst_i,
    input logic                              req_valid_i,
    input muldiv_pkg::muldiv_op_e            op_i,
    input logic [XLEN-1:0]                   rs1_i,
    input logic [XLEN-1:0]                   rs2_i,
    input logic [muldiv_pkg::REG_ADDR_W-1:0] rd_i,
    input logic                              wb_valid_o,
    input logic [XLEN-1:0]                   wb_data_o,
    input logic [muldiv_pkg::REG_ADDR_W-1:0] wb_rd_o,
    input logic                              busy_o,
    input muldiv_pkg::div_state_e            div_state
);
    import muldiv_pkg::*;

    localparam int NREG = 2 ** REG_ADDR_W;

    // in-flight table, indexed by rd
    muldiv_op_e            t_op [NREG];
    logic [XLEN-1:0]       t_a [NREG];
    logic [XLEN-1:0]       t_b [NREG];
    logic                  t_live [NREG];
    int                    t_due [NREG];  // cycle the writeback must show up

    int                    cyc = 0;
    int                    err_cnt = 0;
    logic                  held = 1'b0;     // divide request being held
    logic                  pending = 1'b0;  // held divide not yet written back
    logic [REG_ADDR_W-1:0] held_rd = '0;
    logic                  accept_mul;
    logic                  accept_div;
    logic [XLEN-1:0]       exp_val;

    // RV32M rules, widened to XLEN
    function automatic logic [XLEN-1:0] ref_result(muldiv_op_e op, logic [XLEN-1:0] a,
                                                   logic [XLEN-1:0] b);
        logic signed [2*XLEN-1:0] sa;
        logic signed [2*XLEN-1:0] sb;
        logic signed [2*XLEN-1:0] ub;
        logic [2*XLEN-1:0]        p;
        logic [XLEN-1:0]          minv;
        minv = {1'b1, {(XLEN-1){1'b0}}};
        sa = {{XLEN{a[XLEN-1]}}, a};
        sb = {{XLEN{b[XLEN-1]}}, b};
        ub = {{XLEN{1'b0}}, b};
        p  = '0;
        case (op)
            OP_MUL: begin
                p = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
                return p[XLEN-1:0];
            end
            OP_MULH: begin
                p = sa * sb;
                return p[2*XLEN-1:XLEN];
            end
            OP_MULHSU: begin
                p = sa * ub;
                return p[2*XLEN-1:XLEN];
            end
            OP_MULHU: begin
                p = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
                return p[2*XLEN-1:XLEN];
            end
            OP_DIV: begin
                if (b == '0) return '1;
                if (a == minv && b == '1) return minv;  // wraps
                p = sa / sb;
                return p[XLEN-1:0];
            end
            OP_DIVU: begin
                if (b == '0) return '1;
                return a / b;
            end
            OP_REM: begin
                if (b == '0) return a;
                if (a == minv && b == '1) return '0;
                p = sa % sb;
                return p[XLEN-1:0];
            end
            OP_REMU: begin
                if (b == '0) return a;
                return a % b;
            end
            default: return '0;
        endcase
    endfunction

    assign accept_mul = req_valid_i && !op_i[3] && !busy_o;
    assign accept_div = req_valid_i && op_i[3] && !busy_o && !held;
    assign exp_val    = ref_result(t_op[wb_rd_o], t_a[wb_rd_o], t_b[wb_rd_o]);

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    always @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < NREG; i++) begin
                t_live[i] <= 1'b0;
            end
            held    <= 1'b0;
            pending <= 1'b0;
        end else begin
            if (wb_valid_o) begin
                t_live[wb_rd_o] <= 1'b0;
                if (pending && wb_rd_o == held_rd) pending <= 1'b0;
            end
            if (held && !req_valid_i) begin
                held <= 1'b0;
                if (pending) begin  // abort, no writeback allowed
                    pending         <= 1'b0;
                    t_live[held_rd] <= 1'b0;
                end
            end
            if (accept_mul || accept_div) begin
                t_op[rd_i]   <= op_i;
                t_a[rd_i]    <= rs1_i;
                t_b[rd_i]    <= rs2_i;
                t_live[rd_i] <= 1'b1;
                if (accept_div) begin
                    t_due[rd_i] <= cyc + ((rs2_i == '0) ? 3 : 35);
                    held        <= 1'b1;
                    pending     <= 1'b1;
                    held_rd     <= rd_i;
                end else begin
                    t_due[rd_i] <= cyc + 3;
                end
            end
        end
    end

    a_reset: assert property (@(posedge clk)
        rst_i |=> (!wb_valid_o && !busy_o && div_state == DIV_IDLE))
        else begin
            $error("wb_valid_o, busy_o or the divider state is wrong right after reset");
            err_cnt = err_cnt + 1;
        end

    // busy from the cycle after acceptance until the result strobe
    a_busy_div: assert property (@(posedge clk) disable iff (rst_i)
        (held && pending) |-> (busy_o == (cyc < t_due[held_rd] - 1)))
        else begin
            $error("busy_o did not follow the divide in flight at cycle %0d",
                   $sampled(cyc));
            err_cnt = err_cnt + 1;
        end

    a_no_issue_busy: assert property (@(posedge clk) disable iff (rst_i)
        (busy_o && req_valid_i) |-> (held && op_i[3] && rd_i == held_rd))
        else begin
            $error("a new request was issued while busy_o was high");
            err_cnt = err_cnt + 1;
        end

    a_abort_busy: assert property (@(posedge clk) disable iff (rst_i)
        (held && pending && !req_valid_i) |=> !busy_o)
        else begin
            $error("busy_o did not fall the cycle after a divide was abandoned");
            err_cnt = err_cnt + 1;
        end

    a_wb_known: assert property (@(posedge clk) disable iff (rst_i)
        wb_valid_o |-> t_live[wb_rd_o])
        else begin
            $error("writeback to rd %0d which has no request in flight", $sampled(wb_rd_o));
            err_cnt = err_cnt + 1;
        end

    a_wb_data: assert property (@(posedge clk) disable iff (rst_i)
        (wb_valid_o && t_live[wb_rd_o]) |-> (wb_data_o == exp_val))
        else begin
            $error("error wb_data_o %h expected %h", $sampled(wb_data_o), $sampled(exp_val));
            err_cnt = err_cnt + 1;
        end

    a_wb_time: assert property (@(posedge clk) disable iff (rst_i)
        (wb_valid_o && t_live[wb_rd_o]) |-> (cyc == t_due[wb_rd_o]))
        else begin
            $error("writeback to rd %0d came at cycle %0d instead of %0d",
                   $sampled(wb_rd_o), $sampled(cyc), $sampled(t_due[wb_rd_o]));
            err_cnt = err_cnt + 1;
        end

endmodule

bind exu_muldiv tb_muldiv_asserts #(
    .XLEN(XLEN)
) i_chk (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .op_i        (op_i),
    .rs1_i       (rs1_i),
    .rs2_i       (rs2_i),
    .rd_i        (rd_i),
    .wb_valid_o  (wb_valid_o),
    .wb_data_o   (wb_data_o),
    .wb_rd_o     (wb_rd_o),
    .busy_o      (busy_o),
    .div_state   (i_div.state_q)
);

// File: verilog.f
hw/muldiv_pkg.sv
hw/exu_div.sv
hw/exu_mul.sv
hw/muldiv_wb.sv
hw/exu_muldiv.sv
verification/tb_muldiv_asserts.sv
verification/tb_muldiv.sv
